//--- Makefile
# Verilator build and run for the CoCo3 tape and reset glue

VERILATOR ?= verilator
TOP       ?= tb_coco_host_glue
FILELIST  ?= coco_host_glue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; \
	else echo "Simulation passed"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- coco_host_glue.f
src/host_glue_pkg.sv
src/tape_buffer.sv
src/cassette_player.sv
src/machine_reset_ctrl.sv
src/coco_host_glue.sv
verif/tb_coco_host_glue.sv

//--- src/cassette_player.sv
// Cassette player; plays only while motor is high, MSB first, a rewind aborts any read in flight
`timescale 1ns/1ps
`default_nettype none

module cassette_player
(
	input  logic                          clk_sys,
	input  logic                          arst_n,
	// Core relay and menu controls
	input  logic                          motor,
	input  logic                          tape_rewind,
	input  logic                          tape_loaded,
	input  logic                          tape_monitor,
	input  host_glue_pkg::audio_sample_t  core_audio,
	// Buffer read port
	input  logic                          rd_ack,
	input  host_glue_pkg::tape_byte_t     rd_data,
	output logic                          rd_req,
	output host_glue_pkg::tape_addr_t     rd_addr,
	// Toward the core
	output logic                          tape_bit,
	output host_glue_pkg::audio_sample_t  audio_out
);
	import host_glue_pkg::*;

	player_state_t        state;
	tape_byte_t           cur_byte;
	tape_byte_t           next_byte;
	logic [2:0]           bit_cnt;
	logic [BIT_CYC_W-1:0] cyc_cnt;

	logic shifting;
	logic fetch_done;
	logic last_cyc;
	logic byte_end;
	logic bit_step;
	logic load_first;
	logic bypass;
	logic from_next;
	logic take_next;

	// ==============================
	// Decode
	// ==============================
	assign shifting   = (state == PL_SHIFT) || (state == PL_SHIFT_NEXT);
	assign fetch_done = rd_req && rd_ack;
	assign last_cyc   = (cyc_cnt == BIT_CYC_W'(BIT_CYCLES - 1));
	assign byte_end   = shifting && last_cyc && (bit_cnt == 3'd7);
	assign bit_step   = shifting && last_cyc && !byte_end;
	// First byte after idle or after a gap
	assign load_first = (state == PL_FETCH) && fetch_done && motor;
	// Prefetch landed exactly on the byte boundary
	assign bypass     = (state == PL_SHIFT) && byte_end && fetch_done && motor;
	assign from_next  = (state == PL_SHIFT_NEXT) && byte_end && motor;
	assign take_next  = (state == PL_SHIFT) && fetch_done && !byte_end;

	// Bit goes out only while a byte is shifting
	assign tape_bit = shifting && cur_byte[7];

	// Monitor mix into left audio
	always_comb
	begin
		audio_out = core_audio;
		audio_out[MONITOR_BIT] = core_audio[MONITOR_BIT] ^ (tape_monitor && tape_bit);
	end

	// Byte registers
	always_ff @(posedge clk_sys)
	begin
		if (load_first || bypass)
			cur_byte <= rd_data;
		else if (from_next)
			cur_byte <= next_byte;
		else if (bit_step)
			cur_byte <= {cur_byte[6:0], 1'b0};
		if (take_next)
			next_byte <= rd_data;
	end

	// ==============================
	// Player FSM
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= PL_IDLE;
			rd_req  <= 1'b0;
			rd_addr <= '0;
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end
		else if (tape_rewind || tape_loaded)
		begin
			// Back to the start of the image, data dropped
			state   <= PL_IDLE;
			rd_req  <= 1'b0;
			rd_addr <= '0;
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end
		else
		begin
			if (fetch_done)
			begin
				rd_req  <= 1'b0;
				rd_addr <= rd_addr + 1'b1;
			end
			// Bit timing
			if (shifting)
				cyc_cnt <= last_cyc ? '0 : cyc_cnt + 1'b1;
			if (bit_step)
				bit_cnt <= bit_cnt + 1'b1;

			unique case (state)
				PL_IDLE:
					// Wait until the last ack is gone
					if (motor && !rd_ack)
					begin
						rd_req <= 1'b1;
						state  <= PL_FETCH;
					end
				PL_FETCH:
					if (fetch_done)
					begin
						if (motor)
						begin
							state   <= PL_SHIFT;
							bit_cnt <= '0;
							cyc_cnt <= '0;
						end
						else
						begin
							// Motor gone, byte stays unplayed
							state   <= PL_IDLE;
							rd_addr <= rd_addr;
						end
					end
				PL_SHIFT:
					if (byte_end)
					begin
						bit_cnt <= '0;
						if (fetch_done && !motor)
						begin
							state   <= PL_IDLE;
							rd_addr <= rd_addr;
						end
						else if (!fetch_done)
							// Prefetch still stalled or never issued
							state <= rd_req ? PL_FETCH : PL_IDLE;
					end
					else if (fetch_done)
						state <= PL_SHIFT_NEXT;
					else if (motor && !rd_req && !rd_ack)
						rd_req <= 1'b1;
				PL_SHIFT_NEXT:
					if (byte_end)
					begin
						bit_cnt <= '0;
						if (motor)
							state <= PL_SHIFT;
						else
						begin
							// Prefetched byte dropped, point back at it
							state   <= PL_IDLE;
							rd_addr <= rd_addr - 1'b1;
						end
					end
			endcase
		end
	end

	// New request only once the previous ack has dropped
	a_req_after_ack: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(rd_req) |-> !rd_ack)
		else $error("rd_req rose while rd_ack was high");

endmodule

`default_nettype wire

//--- src/coco_host_glue.sv
// Top of the CoCo3 tape and reset glue; all ports on clk_sys, no video, SD or SDRAM paths
`timescale 1ns/1ps
`default_nettype none

module coco_host_glue
(
	input  logic                          clk_sys,
	input  logic                          arst_n,
	// Host side
	input  logic                          load_active,
	input  logic                          load_wr,
	input  host_glue_pkg::load_index_t    load_index,
	input  host_glue_pkg::load_addr_t     load_addr,
	input  host_glue_pkg::tape_byte_t     load_data,
	input  logic                          tape_rewind,
	input  logic                          tape_monitor,
	input  logic                          menu_reset,
	input  logic                          user_button,
	input  logic                          cold_boot_menu,
	input  host_glue_pkg::slot_sel_t      slot_sel,
	input  host_glue_pkg::mem_size_t      mem_size,
	// Core side
	input  logic                          motor,
	input  host_glue_pkg::audio_sample_t  core_audio,
	input  logic                          cold_ack,
	output logic                          tape_bit,
	output host_glue_pkg::audio_sample_t  audio_out,
	output logic                          cold_req,
	output logic                          core_reset_n
);
	import host_glue_pkg::*;

	// Buffer to player read channel
	logic       tape_loaded;
	logic       rd_req;
	logic       rd_ack;
	tape_addr_t rd_addr;
	tape_byte_t rd_data;

	// ==============================
	// Cassette path
	// ==============================
	tape_buffer u_tape_buffer (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_ack      (rd_ack),
		.rd_data     (rd_data),
		.tape_loaded (tape_loaded)
	);

	cassette_player u_cassette_player (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.motor        (motor),
		.tape_rewind  (tape_rewind),
		.tape_loaded  (tape_loaded),
		.tape_monitor (tape_monitor),
		.core_audio   (core_audio),
		.rd_ack       (rd_ack),
		.rd_data      (rd_data),
		.rd_req       (rd_req),
		.rd_addr      (rd_addr),
		.tape_bit     (tape_bit),
		.audio_out    (audio_out)
	);

	// Reset and cold boot
	machine_reset_ctrl u_machine_reset_ctrl (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.menu_reset     (menu_reset),
		.user_button    (user_button),
		.cold_boot_menu (cold_boot_menu),
		.slot_sel       (slot_sel),
		.mem_size       (mem_size),
		.cold_ack       (cold_ack),
		.core_reset_n   (core_reset_n),
		.cold_req       (cold_req)
	);

endmodule

`default_nettype wire

//--- src/host_glue_pkg.sv
// Shared types for the CoCo3 tape and reset glue; one clk_sys domain, BIT_CYCLES is shortened for simulation
`default_nettype none

package host_glue_pkg;

	// ==============================
	// Vector types
	// ==============================

	// Byte address inside the tape buffer
	typedef logic [15:0] tape_addr_t;
	typedef logic [7:0]  tape_byte_t;
	// Host download address, only the low 16 bits reach the buffer
	typedef logic [24:0] load_addr_t;
	typedef logic [7:0]  load_index_t;
	typedef logic [15:0] audio_sample_t;
	// Multi-Pak slot and memory size menu codes
	typedef logic [1:0]  slot_sel_t;
	typedef logic [2:0]  mem_size_t;

	// ==============================
	// Tape constants
	// ==============================

	localparam int TAPE_DEPTH      = 65536;
	// Download index of a cassette image
	localparam int TAPE_LOAD_INDEX = 2;
	// Clocks per tape bit, far shorter than the real Q clock
	localparam int BIT_CYCLES      = 8;
	// Audio bit flipped by the tape monitor
	localparam int MONITOR_BIT     = 13;
	// Edges from sampled rd_req to rd_ack
	localparam int BUF_READ_CYCLES = 2;

	// Derived counter widths
	localparam int BIT_CYC_W = $clog2(BIT_CYCLES);
	localparam int RD_CNT_W  = $clog2(BUF_READ_CYCLES) + 1;

	// ==============================
	// State machines
	// ==============================

	// Shift_next means a prefetched byte waits behind the current one
	typedef enum logic [1:0] {PL_IDLE, PL_FETCH, PL_SHIFT, PL_SHIFT_NEXT} player_state_t;

	// Cold boot four-phase handshake toward the core
	typedef enum logic [1:0] {CB_QUIET, CB_REQ, CB_WAIT_ACK_LOW} cold_state_t;

endpackage

`default_nettype wire

//--- src/machine_reset_ctrl.sv
// Core reset and cold boot control; the first slot or memory change after reset is ignored
`timescale 1ns/1ps
`default_nettype none

module machine_reset_ctrl
(
	input  logic                       clk_sys,
	input  logic                       arst_n,
	// Reset sources
	input  logic                       menu_reset,
	input  logic                       user_button,
	input  logic                       cold_boot_menu,
	// Menu configuration
	input  host_glue_pkg::slot_sel_t   slot_sel,
	input  host_glue_pkg::mem_size_t   mem_size,
	// Core handshake
	input  logic                       cold_ack,
	output logic                       core_reset_n,
	output logic                       cold_req
);
	import host_glue_pkg::*;

	slot_sel_t   slot_d;
	mem_size_t   mem_d;
	logic        slot_seen;
	logic        mem_seen;
	logic        slot_evt;
	logic        mem_evt;
	logic        menu_evt;
	cold_state_t cold_state;

	// Reset combiner
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			core_reset_n <= 1'b0;
		else
			core_reset_n <= !(menu_reset || user_button);
	end

	// ==============================
	// Configuration change watcher
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			slot_d    <= '0;
			mem_d     <= '0;
			slot_seen <= 1'b0;
			mem_seen  <= 1'b0;
			slot_evt  <= 1'b0;
			mem_evt   <= 1'b0;
			menu_evt  <= 1'b0;
		end
		else
		begin
			slot_d   <= slot_sel;
			mem_d    <= mem_size;
			slot_evt <= 1'b0;
			mem_evt  <= 1'b0;
			menu_evt <= cold_boot_menu;
			// First change only arms the watcher
			if (slot_sel != slot_d)
			begin
				if (!slot_seen)
					slot_seen <= 1'b1;
				else
					slot_evt <= 1'b1;
			end
			if (mem_size != mem_d)
			begin
				if (!mem_seen)
					mem_seen <= 1'b1;
				else
					mem_evt <= 1'b1;
			end
		end
	end

	// Cold boot handshake, events during a run merge into it
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			cold_state <= CB_QUIET;
		else
		begin
			unique case (cold_state)
				CB_QUIET:
					if (slot_evt || mem_evt || menu_evt)
						cold_state <= CB_REQ;
				CB_REQ:
					if (cold_ack)
						cold_state <= CB_WAIT_ACK_LOW;
				CB_WAIT_ACK_LOW:
					if (!cold_ack)
						cold_state <= CB_QUIET;
				default:
					cold_state <= CB_QUIET;
			endcase
		end
	end

	assign cold_req = (cold_state == CB_REQ);

	// Ack has to rise during the request, a stale ack would end it at once
	a_ack_after_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(cold_req) |-> !cold_ack)
		else $error("cold_ack was already high when cold_req rose");

endmodule

`default_nettype wire

//--- src/tape_buffer.sv
// Tape RAM of 64 KiB; download writes win over player reads, reads stall while load_active is high
`timescale 1ns/1ps
`default_nettype none

module tape_buffer
(
	input  logic                        clk_sys,
	input  logic                        arst_n,
	// Host download side
	input  logic                        load_active,
	input  logic                        load_wr,
	input  host_glue_pkg::load_index_t  load_index,
	input  host_glue_pkg::load_addr_t   load_addr,
	input  host_glue_pkg::tape_byte_t   load_data,
	// Player read side, four-phase
	input  logic                        rd_req,
	input  host_glue_pkg::tape_addr_t   rd_addr,
	output logic                        rd_ack,
	output host_glue_pkg::tape_byte_t   rd_data,
	output logic                        tape_loaded
);
	import host_glue_pkg::*;

	tape_byte_t          mem [TAPE_DEPTH];
	tape_addr_t          ram_addr;
	logic [RD_CNT_W-1:0] rd_cnt;
	logic                tape_wr;
	logic                rd_done;

	// Only cassette images land here
	assign tape_wr = load_wr && (load_index == load_index_t'(TAPE_LOAD_INDEX));

	// Last latency step of a running read
	assign rd_done = rd_req && !rd_ack && !load_active
		&& (rd_cnt == RD_CNT_W'(BUF_READ_CYCLES - 1));

	// Download write port
	always_ff @(posedge clk_sys)
	begin
		if (tape_wr)
		begin
			mem[load_addr[$bits(tape_addr_t)-1:0]] <= load_data;
		end
	end

	// Registered RAM address, download has priority
	always_ff @(posedge clk_sys)
	begin
		ram_addr <= load_active ? load_addr[$bits(tape_addr_t)-1:0] : rd_addr;
	end

	// Read data, held while rd_ack is up
	always_ff @(posedge clk_sys)
	begin
		if (rd_done)
		begin
			rd_data <= mem[ram_addr];
		end
	end

	// ==============================
	// Handshake and latency counter
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_ack      <= 1'b0;
			rd_cnt      <= '0;
			tape_loaded <= 1'b0;
		end
		else
		begin
			// One pulse per tape byte, rewinds the player
			tape_loaded <= tape_wr;
			if (rd_ack)
			begin
				if (!rd_req)
					rd_ack <= 1'b0;
			end
			else if (load_active || !rd_req)
				// Address was overwritten or request withdrawn, start over
				rd_cnt <= '0;
			else if (rd_done)
			begin
				rd_ack <= 1'b1;
				rd_cnt <= '0;
			end
			else
				rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// Player must hold its address for the whole request
	a_rd_addr_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rd_req && $past(rd_req) |-> rd_addr == $past(rd_addr))
		else $error("rd_addr changed while rd_req was high");

endmodule

`default_nettype wire

//--- verif/tb_coco_host_glue.sv
// Testbench for the tape and reset glue; 32 byte image, each config setting ignores its first change
`timescale 1ns/1ps
`default_nettype none

module tb_coco_host_glue;
	import host_glue_pkg::*;

	localparam int CLK_HALF_NS  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int IMAGE_BYTES  = 32;
	localparam int AUDIO_STEPS  = 200;
	// Tape bits sampled over all tests
	localparam int PLAY_BITS    = 256 + 16;
	localparam int TEST_CYCLES  = RESET_CYCLES + 4 * IMAGE_BYTES + PLAY_BITS * BIT_CYCLES
		+ AUDIO_STEPS + 400;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

	logic          clk_sys;
	logic          arst_n;
	logic          load_active;
	logic          load_wr;
	load_index_t   load_index;
	load_addr_t    load_addr;
	tape_byte_t    load_data;
	logic          tape_rewind;
	logic          tape_monitor;
	logic          menu_reset;
	logic          user_button;
	logic          cold_boot_menu;
	slot_sel_t     slot_sel;
	mem_size_t     mem_size;
	logic          motor;
	audio_sample_t core_audio;
	logic          cold_ack;
	logic          tape_bit;
	audio_sample_t audio_out;
	logic          cold_req;
	logic          core_reset_n;

	logic [15:0] lfsr;
	tape_byte_t  image [IMAGE_BYTES];
	int          err_count;
	int          check_count;
	int          test_count;
	int          test_errs;
	int          flips;
	logic        exp_bit;

	coco_host_glue dut_i (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.load_active(load_active), .load_wr(load_wr), .load_index(load_index),
		.load_addr(load_addr), .load_data(load_data),
		.tape_rewind(tape_rewind), .tape_monitor(tape_monitor),
		.menu_reset(menu_reset), .user_button(user_button), .cold_boot_menu(cold_boot_menu),
		.slot_sel(slot_sel), .mem_size(mem_size),
		.motor(motor), .core_audio(core_audio), .cold_ack(cold_ack),
		.tape_bit(tape_bit), .audio_out(audio_out), .cold_req(cold_req),
		.core_reset_n(core_reset_n)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #(CLK_HALF_NS) clk_sys = ~clk_sys;
	end

	// ==============================
	// Random source and reference model
	// ==============================

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
			val = {val[14:0], lfsr_step()};
		return val;
	endfunction

	// Bit n of the image, MSB of each byte first
	function automatic logic expected_tape_bit(input int n);
		tape_byte_t b;
		b = image[n / 8];
		return b[7 - (n % 8)];
	endfunction

	function automatic audio_sample_t expected_audio(input audio_sample_t sample,
		input logic monitor, input logic bit_in);
		audio_sample_t res;
		res = sample;
		if (monitor && bit_in)
			res[MONITOR_BIT] = ~res[MONITOR_BIT];
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
		test_errs = err_count;
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================

	// One full image burst, recorded only when it is a cassette image
	task automatic download(input load_index_t index, input logic to_image);
		tape_byte_t val;
		load_active = 1'b1;
		load_index  = index;
		for (int i = 0; i < IMAGE_BYTES; i++)
		begin
			val = tape_byte_t'(rand_bits(8));
			if (to_image)
				image[i] = val;
			load_wr   = 1'b1;
			load_addr = load_addr_t'(i);
			load_data = val;
			@(negedge clk_sys);
		end
		load_wr     = 1'b0;
		load_active = 1'b0;
		@(negedge clk_sys);
	endtask

	// Motor on in idle, returns mid first bit
	task automatic start_motor();
		motor = 1'b1;
		// E0
		@(posedge clk_sys);
		repeat (3) @(posedge clk_sys);
		repeat (BIT_CYCLES / 2 + 1) @(negedge clk_sys);
	endtask

	// Mid-bit samples, ends in the middle of the last one
	task automatic sample_bits(input int first, input int count);
		for (int n = first; n < first + count; n++)
		begin
			check_value($sformatf("tape_bit[%0d]", n), 32'(tape_bit), 32'(expected_tape_bit(n)));
			if (n < first + count - 1)
				repeat (BIT_CYCLES) @(negedge clk_sys);
		end
	endtask

	task automatic wait_cold_req(input logic level, input string what);
		int n;
		n = 0;
		while (cold_req !== level && n < 20)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (cold_req !== level)
		begin
			err_count++;
			$display("cold_req did not go to %0d within 20 cycles %s", level, what);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk_sys);
			check_value("cold_req", 32'(cold_req), 32'd0);
		end
	endtask

	// Four-phase cold boot exchange as the core
	task automatic cold_handshake(input string what);
		wait_cold_req(1'b1, what);
		// Request holds until the ack
		repeat (5)
		begin
			@(negedge clk_sys);
			check_value("cold_req", 32'(cold_req), 32'd1);
		end
		cold_ack = 1'b1;
		wait_cold_req(1'b0, what);
		@(negedge clk_sys);
		cold_ack = 1'b0;
		expect_quiet(3);
	endtask

	task automatic hold_reset_source(input logic use_button);
		if (use_button)
			user_button = 1'b1;
		else
			menu_reset = 1'b1;
		repeat (4)
		begin
			@(negedge clk_sys);
			check_value("core_reset_n", 32'(core_reset_n), 32'd0);
		end
		menu_reset  = 1'b0;
		user_button = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset_n", 32'(core_reset_n), 32'd1);
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial
	begin
		arst_n = 1'b0;
		load_active = 1'b0;
		load_wr = 1'b0;
		load_index = '0;
		load_addr = '0;
		load_data = '0;
		tape_rewind = 1'b0;
		tape_monitor = 1'b0;
		menu_reset = 1'b0;
		user_button = 1'b0;
		cold_boot_menu = 1'b0;
		slot_sel = '0;
		mem_size = '0;
		motor = 1'b0;
		core_audio = '0;
		cold_ack = 1'b0;
		lfsr = 16'd6727;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		test_errs = 0;
		flips = 0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		check_value("core_reset_n", 32'(core_reset_n), 32'd0);
		arst_n = 1'b1;
		repeat (2) @(negedge clk_sys);

		// Cassette image, then a foreign image that must not land in the tape buffer
		download(load_index_t'(TAPE_LOAD_INDEX), 1'b1);
		download(load_index_t'(5), 1'b0);
		repeat (4) @(negedge clk_sys);
		start_motor();
		sample_bits(0, 160);
		end_test("download and playback");

		// Motor drops mid byte 20
		repeat (BIT_CYCLES) @(negedge clk_sys);
		sample_bits(160, 3);
		motor = 1'b0;
		repeat (BIT_CYCLES) @(negedge clk_sys);
		sample_bits(163, 5);
		repeat (BIT_CYCLES / 2) @(negedge clk_sys);
		repeat (3 * BIT_CYCLES)
		begin
			check_value("tape_bit idle", 32'(tape_bit), 32'd0);
			@(negedge clk_sys);
		end
		start_motor();
		sample_bits(168, 88);
		motor = 1'b0;
		repeat (2 * BIT_CYCLES) @(negedge clk_sys);
		tape_rewind = 1'b1;
		@(negedge clk_sys);
		tape_rewind = 1'b0;
		repeat (4) @(negedge clk_sys);
		start_motor();
		sample_bits(0, 16);
		motor = 1'b0;
		repeat (2 * BIT_CYCLES) @(negedge clk_sys);
		end_test("motor stop and rewind");

		// Audio mix, monitor on for the second half
		// Playback resumes at byte 2, its first bit shows from the fourth step on
		motor = 1'b1;
		for (int i = 0; i < AUDIO_STEPS; i++)
		begin
			@(negedge clk_sys);
			core_audio   = rand_bits(16);
			tape_monitor = (i >= AUDIO_STEPS / 2);
			exp_bit      = (i >= 3) ? expected_tape_bit(16 + (i - 3) / BIT_CYCLES) : 1'b0;
			#1;
			check_value("tape_bit", 32'(tape_bit), 32'(exp_bit));
			check_value("audio_out", 32'(audio_out),
				32'(expected_audio(core_audio, tape_monitor, exp_bit)));
			if (tape_monitor && tape_bit)
				flips++;
		end
		if (flips == 0)
		begin
			err_count++;
			$display("tape_bit was never high while the monitor was on");
		end
		@(negedge clk_sys);
		motor = 1'b0;
		tape_monitor = 1'b0;
		end_test("audio monitor");

		// Each setting has its own first-change filter
		slot_sel = 2'd1;
		expect_quiet(10);
		slot_sel = 2'd2;
		cold_handshake("after slot change");
		mem_size = 3'd1;
		expect_quiet(10);
		mem_size = 3'd2;
		cold_handshake("after memory size change");
		end_test("config cold boot");

		cold_boot_menu = 1'b1;
		@(negedge clk_sys);
		cold_boot_menu = 1'b0;
		cold_handshake("after menu cold boot");
		end_test("menu cold boot");

		check_value("core_reset_n", 32'(core_reset_n), 32'd1);
		hold_reset_source(1'b0);
		hold_reset_source(1'b1);
		end_test("core reset sources");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
